// ==== sifhTop.f ====
src/sifhPkg.sv
src/sifhControl.sv
src/histRam.sv
src/binUpdate.sv
src/peakFinder.sv
src/sifhTop.sv
testbench/sifhTop_sva.sv
testbench/sifhTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module sifhTb -f sifhTop.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VsifhTb 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^TEST PASS$'; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in the simulation output"
    exit 1
fi

// ==== testbench/sifhTb.sv ====
module sifhTb;
    import sifhPkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_EVENTS  = 500;
    localparam int SAT_EVENTS   = 300;
    localparam int RUNS         = 6;     // acquisitions in the sequence
    localparam int EVENT_CYCLES = 2 * RAND_EVENTS + SAT_EVENTS + 400;
    localparam int READ_CYCLES  = 4 * RUNS * BIN_NUM;
    localparam int LIMIT_CYCLES = RESET_CYCLES + RUNS * (2 * BIN_NUM + 40)
                                  + EVENT_CYCLES + READ_CYCLES;

    logic  clk;
    logic  res;
    logic  start;
    logic  stop;
    logic  eventValid;
    binT   eventBin;
    logic  rdReq;
    binT   rdBin;
    logic  ready;
    logic  busy;
    logic  rdValid;
    countT rdCount;
    logic  done;
    binT   peakBin;
    countT peakCount;

    countT      refHist [BIN_NUM];   // expected histogram
    binT        pendingReads [$];    // requested bins not yet returned
    logic [7:0] lfsrState;
    bit         acquiring;           // between end of clear and stop

    sifhTop DUT (
        .clk        (clk),
        .res        (res),
        .start      (start),
        .stop       (stop),
        .eventValid (eventValid),
        .eventBin   (eventBin),
        .rdReq      (rdReq),
        .rdBin      (rdBin),
        .ready      (ready),
        .busy       (busy),
        .rdValid    (rdValid),
        .rdCount    (rdCount),
        .done       (done),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [7:0] lfsrStep(input logic [7:0] s);
        logic [7:0] next;
        next = s >> 1;
        if (s[0]) begin
            next = next ^ 8'hB8;    // x^8 + x^6 + x^5 + x^4 + 1
        end
        return next;
    endfunction

    function automatic int takeBits(input int n);
        int value;
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = lfsrStep(lfsrState);
        end
        return value;
    endfunction

    function automatic countT satInc(input countT c);
        int n;
        n = int'(c) + 1;
        if (n > COUNT_MAX) begin
            n = COUNT_MAX;
        end
        return countT'(n);
    endfunction

    // highest count with the lowest bin winning a tie
    function automatic logic [BIN_BITS+COUNT_BITS-1:0] refPeak();
        int best;
        int i;
        best = 0;
        for (i = 1; i < BIN_NUM; i++) begin
            if (refHist[i] > refHist[best]) begin
                best = i;
            end
        end
        return {binT'(best), refHist[best]};
    endfunction

    task automatic sendEvent(input binT b);
        eventValid = 1'b1;
        eventBin   = b;
        checkValue("ready", int'(ready), int'(acquiring));
        if (acquiring) begin
            refHist[b] = satInc(refHist[b]);    // events during clear are dropped
        end
        @(negedge clk);
        eventValid = 1'b0;
    endtask

    task automatic startRun(input bit noisy);
        int n;
        checkValue("busy", int'(busy), 0);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        checkValue("busy", int'(busy), 1);
        for (n = 0; n < BIN_NUM; n++) begin
            refHist[n] = '0;
        end
        n = 0;
        while (!ready) begin
            if (n > BIN_NUM + 4) begin
                abortRun("ready did not rise after start");
            end
            if (noisy) begin
                sendEvent(binT'(takeBits(BIN_BITS)));   // must be ignored
            end else begin
                @(negedge clk);
            end
            n++;
        end
        acquiring = 1'b1;
    endtask

    task automatic stopRun();
        int n;
        acquiring = 1'b0;
        stop = 1'b1;
        @(negedge clk);
        stop = 1'b0;
        checkValue("ready", int'(ready), 0);
        n = 0;
        while (!done) begin
            if (n > 2 * BIN_NUM) begin
                abortRun("done did not arrive after stop");
            end
            @(negedge clk);
            n++;
        end
        @(negedge clk);
    endtask

    task automatic readBin(input binT b);
        int n;
        checkValue("busy", int'(busy), 0);
        rdReq = 1'b1;
        rdBin = b;
        pendingReads.push_back(b);
        @(negedge clk);
        rdReq = 1'b0;
        n = 0;
        while (!rdValid) begin
            if (n > 4) begin
                abortRun("rdValid did not follow rdReq");
            end
            @(negedge clk);
            n++;
        end
        checkValue("rdValid latency", n + 1, 2);
    endtask

    task automatic readAll();
        int i;
        for (i = 0; i < BIN_NUM; i++) begin
            readBin(binT'(i));
        end
    endtask

    // compares every readout and peak result with the model
    always @(negedge clk) begin
        binT                          b;
        logic [BIN_BITS+COUNT_BITS-1:0] peak;
        if (res) begin
            if (rdValid) begin
                if (pendingReads.size() == 0) begin
                    abortRun("rdValid arrived without a pending request");
                end else begin
                    b = pendingReads.pop_front();
                    checkValue($sformatf("rdCount of bin %0d", b), int'(rdCount),
                               int'(refHist[b]));
                end
            end
            if (done) begin
                peak = refPeak();
                checkValue("peakBin", int'(peakBin),
                           int'(peak[BIN_BITS+COUNT_BITS-1:COUNT_BITS]));
                checkValue("peakCount", int'(peakCount), int'(peak[COUNT_BITS-1:0]));
            end
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        abortRun("simulation did not finish within the time limit");
    end

    initial begin
        int i;
        clk        = 1'b0;
        res        = 1'b0;
        start      = 1'b0;
        stop       = 1'b0;
        eventValid = 1'b0;
        eventBin   = '0;
        rdReq      = 1'b0;
        rdBin      = '0;
        lfsrState  = 8'd168;
        acquiring  = 1'b0;
        for (i = 0; i < BIN_NUM; i++) begin
            refHist[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        checkValue("ready", int'(ready), 0);
        checkValue("busy", int'(busy), 0);
        checkValue("rdValid", int'(rdValid), 0);
        checkValue("done", int'(done), 0);
        res = 1'b1;
        @(negedge clk);

        startRun(1'b0);     // empty acquisition
        stopRun();
        readAll();

        startRun(1'b0);     // random events with random gaps
        for (i = 0; i < RAND_EVENTS; i++) begin
            if (takeBits(1) == 1) begin
                @(negedge clk);
            end
            sendEvent(binT'(takeBits(BIN_BITS)));
        end
        stopRun();
        readAll();

        startRun(1'b0);     // forwarding patterns
        repeat (12) sendEvent(binT'(3));
        for (i = 0; i < 10; i++) begin
            sendEvent(binT'(20));
            sendEvent(binT'(21));
        end
        for (i = 0; i < 6; i++) begin
            sendEvent(binT'(7));
            sendEvent(binT'(7));
            sendEvent(binT'(8));
        end
        repeat (2) @(negedge clk);
        repeat (5) sendEvent(binT'(3));
        stopRun();
        readAll();

        startRun(1'b0);     // saturation
        repeat (SAT_EVENTS) sendEvent(binT'(33));
        repeat (4) sendEvent(binT'(10));
        stopRun();
        readAll();

        startRun(1'b0);     // tie between bins 12 and 40
        for (i = 0; i < 7; i++) begin
            sendEvent(binT'(40));
            sendEvent(binT'(12));
        end
        repeat (3) sendEvent(binT'(50));
        stopRun();
        readAll();

        startRun(1'b1);     // events during clear are lost and the old histogram is gone
        repeat (20) sendEvent(binT'(takeBits(BIN_BITS)));
        stopRun();
        readAll();

        repeat (2) @(negedge clk);
        if (pendingReads.size() != 0) begin
            abortRun("readouts were still pending at the end");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== testbench/sifhTop_sva.sv ====
module sifhControlSva (
    input logic               clk,
    input logic               res,
    input sifhPkg::ctrlStateT state,
    input logic               ready,
    input logic               done,
    input logic               rdValid,
    input logic               clrEn,
    input logic               accumMode
);
    import sifhPkg::*;

    readyOnlyInAccum: assert property (@(posedge clk) disable iff (!res)
        ready |-> (state == ACCUM))
        else $error("ready is high outside the ACCUM state");

    donePulse: assert property (@(posedge clk) disable iff (!res) done |=> !done)
        else $error("done stayed high for more than one cycle");

    rdValidPulse: assert property (@(posedge clk) disable iff (!res) rdValid |=> !rdValid)
        else $error("rdValid stayed high for more than one cycle");

    // clear and accumulation must never share the RAM ports
    portOwnerExclusive: assert property (@(posedge clk) disable iff (!res)
        !(clrEn && accumMode))
        else $error("clrEn and accumMode are high together");

endmodule

bind sifhControl sifhControlSva uSva (
    .clk       (clk),
    .res       (res),
    .state     (state),
    .ready     (ready),
    .done      (done),
    .rdValid   (rdValid),
    .clrEn     (clrEn),
    .accumMode (accumMode)
);

// ==== src/sifhTop.sv ====
module sifhTop (
    input  logic            clk,
    input  logic            res,
    input  logic            start,
    input  logic            stop,
    input  logic            eventValid,
    input  sifhPkg::binT    eventBin,
    input  logic            rdReq,
    input  sifhPkg::binT    rdBin,
    output logic            ready,
    output logic            busy,
    output logic            rdValid,
    output sifhPkg::countT  rdCount,
    output logic            done,
    output sifhPkg::binT    peakBin,
    output sifhPkg::countT  peakCount
);
    import sifhPkg::*;

    logic  accumMode;
    logic  clrEn;
    logic  scanStart;
    logic  scanValid;
    logic  pipeBusy;
    logic  accWrEn;
    binT   maintAddr;
    binT   accRdAddr;
    binT   accWrAddr;
    countT accWrData;
    countT ramData;

    sifhControl uControl (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .stop      (stop),
        .rdReq     (rdReq),
        .rdBin     (rdBin),
        .pipeBusy  (pipeBusy),
        .ready     (ready),
        .busy      (busy),
        .accumMode (accumMode),
        .clrEn     (clrEn),
        .scanStart (scanStart),
        .scanValid (scanValid),
        .rdValid   (rdValid),
        .done      (done),
        .maintAddr (maintAddr)
    );

    histRam uRam (
        .clk       (clk),
        .accumMode (accumMode),
        .accRdAddr (accRdAddr),
        .accWrAddr (accWrAddr),
        .maintAddr (maintAddr),
        .accWrEn   (accWrEn),
        .clrEn     (clrEn),
        .accWrData (accWrData),
        .rdData    (ramData)
    );

    binUpdate uUpdate (
        .clk        (clk),
        .res        (res),
        .eventValid (eventValid),
        .eventBin   (eventBin),
        .accept     (ready),
        .rdData     (ramData),
        .accRdAddr  (accRdAddr),
        .accWrAddr  (accWrAddr),
        .accWrEn    (accWrEn),
        .accWrData  (accWrData),
        .pipeBusy   (pipeBusy)
    );

    peakFinder uPeak (
        .clk       (clk),
        .res       (res),
        .scanStart (scanStart),
        .scanValid (scanValid),
        .rdData    (ramData),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    assign rdCount = ramData;   // meaningful while rdValid is high

endmodule

// ==== src/peakFinder.sv ====
module peakFinder (
    input  logic            clk,
    input  logic            res,
    input  logic            scanStart,
    input  logic            scanValid,
    input  sifhPkg::countT  rdData,
    output sifhPkg::binT    peakBin,
    output sifhPkg::countT  peakCount
);
    import sifhPkg::*;

    binT   idx;       // bin whose count is on rdData
    binT   maxBin;
    countT maxCount;
    logic  better;
    logic  lastIdx;

    assign better  = (rdData > maxCount);   // strict, lower bin keeps a tie
    assign lastIdx = (idx == binT'(BIN_NUM - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            idx       <= '0;
            maxBin    <= '0;
            maxCount  <= '0;
            peakBin   <= '0;
            peakCount <= '0;
        end else if (scanStart) begin
            idx      <= '0;
            maxBin   <= '0;
            maxCount <= '0;
        end else if (scanValid) begin
            idx <= idx + 1'b1;
            if (better) begin
                maxBin   <= idx;
                maxCount <= rdData;
            end
            // result only moves once per scan
            if (lastIdx) begin
                peakBin   <= better ? idx : maxBin;
                peakCount <= better ? rdData : maxCount;
            end
        end
    end

endmodule

// ==== src/binUpdate.sv ====
module binUpdate (
    input  logic            clk,
    input  logic            res,
    input  logic            eventValid,
    input  sifhPkg::binT    eventBin,
    input  logic            accept,
    input  sifhPkg::countT  rdData,
    output sifhPkg::binT    accRdAddr,
    output sifhPkg::binT    accWrAddr,
    output logic            accWrEn,
    output sifhPkg::countT  accWrData,
    output logic            pipeBusy
);
    import sifhPkg::*;

    logic  take;      // event accepted into stage 1
    logic  s2Valid;
    binT   s2Bin;
    logic  fwdValid;  // a write happened in the previous cycle
    binT   fwdBin;
    countT fwdCount;
    countT oldCount;

    assign take      = eventValid && accept;
    assign accRdAddr = eventBin;   // stage 1 read, data returns next cycle

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s2Valid  <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            s2Valid  <= take;
            fwdValid <= accWrEn;
        end
    end

    always_ff @(posedge clk) begin
        s2Bin    <= eventBin;
        fwdBin   <= accWrAddr;
        fwdCount <= accWrData;
    end

    // RAM returns the pre-write value when the same bin was written last cycle
    always_comb begin
        if (fwdValid && (fwdBin == s2Bin)) begin
            oldCount = fwdCount;
        end else begin
            oldCount = rdData;
        end
    end

    always_comb begin
        if (oldCount == countT'(COUNT_MAX)) begin
            accWrData = oldCount;  // saturate
        end else begin
            accWrData = oldCount + 1'b1;
        end
    end

    assign accWrEn   = s2Valid;     // written at the end of stage 2
    assign accWrAddr = s2Bin;
    assign pipeBusy  = s2Valid;

endmodule

// ==== src/histRam.sv ====
module histRam (
    input  logic            clk,
    input  logic            accumMode,
    input  sifhPkg::binT    accRdAddr,
    input  sifhPkg::binT    accWrAddr,
    input  sifhPkg::binT    maintAddr,
    input  logic            accWrEn,
    input  logic            clrEn,
    input  sifhPkg::countT  accWrData,
    output sifhPkg::countT  rdData
);
    import sifhPkg::*;

    countT mem [BIN_NUM];

    binT   rdAddr;
    binT   wrAddr;
    logic  wrEn;
    countT wrData;

    // accumulation pipeline owns both ports while accumMode is high
    always_comb begin
        if (accumMode) begin
            rdAddr = accRdAddr;
            wrAddr = accWrAddr;
            wrEn   = accWrEn;
            wrData = accWrData;
        end else begin
            rdAddr = maintAddr;
            wrAddr = maintAddr;
            wrEn   = clrEn;
            wrData = '0;            // clear writes zero
        end
    end

    // read-first, old contents come out on an address clash
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        rdData <= mem[rdAddr];
    end

endmodule

// ==== src/sifhControl.sv ====
module sifhControl (
    input  logic          clk,
    input  logic          res,
    input  logic          start,
    input  logic          stop,
    input  logic          rdReq,
    input  sifhPkg::binT  rdBin,
    input  logic          pipeBusy,
    output logic          ready,
    output logic          busy,
    output logic          accumMode,
    output logic          clrEn,
    output logic          scanStart,
    output logic          scanValid,
    output logic          rdValid,
    output logic          done,
    output sifhPkg::binT  maintAddr
);
    import sifhPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    binT       binCnt;   // shared by clear and scan, also holds readout bin
    logic      scanLast; // data of the last bin is on the read port
    logic      lastBin;

    assign lastBin = (binCnt == binT'(BIN_NUM - 1));

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (start) begin
                    nextState = CLEAR;  // start wins over a readout
                end else if (rdReq) begin
                    nextState = READ;
                end
            end
            CLEAR: begin
                if (lastBin) begin
                    nextState = ACCUM;
                end
            end
            ACCUM: begin
                if (stop) begin
                    nextState = DRAIN;
                end
            end
            DRAIN: begin
                if (!pipeBusy) begin
                    nextState = SCAN;
                end
            end
            SCAN: begin
                if (scanLast) begin
                    nextState = IDLE;   // last comparison happens now
                end
            end
            READ: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state  <= IDLE;
            binCnt <= '0;
        end else begin
            state <= nextState;
            case (state)
                IDLE: begin
                    if (start) begin
                        binCnt <= '0;
                    end else if (rdReq) begin
                        binCnt <= rdBin;    // address for the readout
                    end
                end
                CLEAR, SCAN: begin
                    binCnt <= binCnt + 1'b1; // wraps to 0 after bin 63
                end
                DRAIN: begin
                    binCnt <= '0;           // scan begins at bin 0
                end
                default: begin
                    binCnt <= binCnt;
                end
            endcase
        end
    end

    // strobes aligned to the one cycle RAM read latency
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanStart <= 1'b0;
            scanValid <= 1'b0;
            scanLast  <= 1'b0;
            rdValid   <= 1'b0;
            done      <= 1'b0;
        end else begin
            scanStart <= (state == DRAIN) && !pipeBusy;
            scanValid <= (state == SCAN) && !scanLast;
            scanLast  <= (state == SCAN) && lastBin;
            rdValid   <= (state == READ);
            done      <= (state == SCAN) && scanLast;
        end
    end

    assign ready     = (state == ACCUM);
    assign busy      = (state != IDLE);
    assign accumMode = (state == ACCUM) || (state == DRAIN); // pipeline still writes in drain
    assign clrEn     = (state == CLEAR);
    assign maintAddr = binCnt;

endmodule

// ==== src/sifhPkg.sv ====
package sifhPkg;

    localparam int BIN_BITS   = 6;                     // bin index width
    localparam int BIN_NUM    = 1 << BIN_BITS;         // 64 bins per histogram
    localparam int COUNT_BITS = 8;                     // per-bin counter width
    localparam int COUNT_MAX  = (1 << COUNT_BITS) - 1; // saturation point

    // bin index, taken from the low timestamp bits
    typedef logic [BIN_BITS-1:0] binT;

    // photon count stored in one bin
    typedef logic [COUNT_BITS-1:0] countT;

    // acquisition sequence of the controller
    typedef enum logic [2:0] {
        IDLE,   // waiting for start or readout request
        CLEAR,  // zeroing all bins
        ACCUM,  // accepting photon events
        DRAIN,  // letting the update pipeline finish
        SCAN,   // peak search over all bins
        READ    // single bin readout
    } ctrlStateT;

endpackage
